// ==== flist.f ====
+incdir+rtl
rtl/qla_pkg.sv
rtl/reg_bus_master.sv
rtl/rt_block_write.sv
rtl/cur_cmd_regs.sv
rtl/dac_serializer.sv
rtl/safety_check.sv
rtl/board_regs.sv
rtl/qla_top.sv
tests/qla_tb.sv

// ==== rtl/board_regs.sv ====
// ------------------------------------------------
// channel 0 status/enable register
// ------------------------------------------------
`timescale 1ns/1ps

module board_regs (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        board_wen,
    input  logic [31:0] wdata,
    input  logic [3:0]  wenid,
    input  logic [3:0]  safety_disable,
    output logic [31:0] board_rdata,
    output logic        pwr_enable_cmd,
    output logic [3:0]  amp_enable_cmd,
    output logic [3:0]  amp_enable
);
    logic [3:0] amp_en_reg;   // requested enables

    always_ff @(posedge sysclk) begin
        if (reset) begin
            amp_en_reg     <= 4'h0;
            pwr_enable_cmd <= 1'b0;
            amp_enable_cmd <= 4'h0;
        end else begin
            // command bits are one-cycle pulses
            pwr_enable_cmd <= board_wen & wdata[0];
            amp_enable_cmd <= board_wen ? wdata[4:1] : 4'h0;
            if (board_wen)
                amp_en_reg <= wdata[4:1];
        end
    end

    // tripped axes stay off
    assign amp_enable = amp_en_reg & ~safety_disable;

    // id 27:24, enables 11:8, safety 3:0
    assign board_rdata = {4'h0, ~wenid, 12'h000, amp_enable, 4'h0, safety_disable};

endmodule

// ==== rtl/cur_cmd_regs.sv ====
// ------------------------------------------------
// commanded current registers, readback and
// DAC update request held against busy
// ------------------------------------------------
`timescale 1ns/1ps
`include "qla_consts.svh"

module cur_cmd_regs (
    input  logic           sysclk,
    input  logic           reset,
    input  logic           cmd_wen,
    input  logic           blk_wen,
    input  qla_pkg::chan_t wr_chan,
    input  qla_pkg::chan_t rd_chan,
    input  logic [3:0]     rd_offset,
    input  logic [31:0]    wdata,
    output logic [31:0]    cmd_rdata,
    input  logic [3:0]     amp_enable,
    input  logic           dac_busy,
    output logic           data_ready,
    output qla_pkg::cur_t  cur_cmd [1:`NUM_CHANNELS]
);
    import qla_pkg::*;

    logic cmd_req;   // update pending
    cur_t sel_cmd;
    logic sel_en;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 1; i <= `NUM_CHANNELS; i++)
                cur_cmd[i] <= `CUR_MIDSCALE;
            cmd_req    <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            for (int i = 1; i <= `NUM_CHANNELS; i++) begin
                if (cmd_wen && wr_chan == 4'(i))
                    cur_cmd[i] <= wdata[15:0];
            end
            // block end sets, a free DAC takes it
            if (cmd_wen && blk_wen)
                cmd_req <= 1'b1;
            else if (cmd_req && !dac_busy)
                cmd_req <= 1'b0;
            data_ready <= cmd_req && !dac_busy;   // single-cycle pulse
        end
    end

    // ------------------------------------------------
    // readback
    // ------------------------------------------------
    always_comb begin
        sel_cmd = `CUR_MIDSCALE;
        sel_en  = 1'b0;
        for (int i = 1; i <= `NUM_CHANNELS; i++) begin
            if (rd_chan == 4'(i)) begin
                sel_cmd = cur_cmd[i];
                sel_en  = amp_enable[i-1];
            end
        end
    end

    always_comb begin
        case (rd_offset)
            `OFF_DAC_CTRL:     cmd_rdata = {16'h0, sel_cmd};
            `OFF_MOTOR_STATUS: cmd_rdata = {3'b000, sel_en, 12'h000, sel_cmd};   // enable in bit 28
            default:           cmd_rdata = 32'h0;
        endcase
    end

endmodule

// ==== rtl/dac_serializer.sv ====
// ------------------------------------------------
// quad DAC serial driver, one 24-bit frame per axis
// ------------------------------------------------
`timescale 1ns/1ps
`include "qla_consts.svh"

module dac_serializer (
    input  logic          sysclk,
    input  logic          reset,
    input  logic          data_ready,
    input  qla_pkg::cur_t cur_cmd [1:`NUM_CHANNELS],
    output logic          dac_busy,
    output logic          dac_sclk,
    output logic          dac_mosi,
    output logic          dac_csel
);
    import qla_pkg::*;

    localparam int BIT_W = $clog2(`DAC_FRAME_BITS);

    dac_state_t                 state;
    cur_t                       dac_cmd [4];   // snapshot of the commands
    logic [1:0]                 ch;            // DAC address = axis - 1
    logic [`DAC_FRAME_BITS-1:0] sreg;
    logic [BIT_W-1:0]           bit_cnt;

    // take all four at once so a late write can't split a set
    always_ff @(posedge sysclk) begin
        if (state == DAC_IDLE && data_ready) begin
            for (int i = 1; i <= `NUM_CHANNELS; i++)
                dac_cmd[i-1] <= cur_cmd[i];
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= DAC_IDLE;
            ch       <= 2'd0;
            sreg     <= '0;
            bit_cnt  <= '0;
            dac_sclk <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            case (state)
                DAC_IDLE: begin
                    ch <= 2'd0;
                    if (data_ready)
                        state <= DAC_LOAD;
                end
                DAC_LOAD: begin
                    // opcode, address, command, MSB first
                    sreg     <= {DAC_OP_WRITE_UPDATE, 2'b00, ch, dac_cmd[ch]};
                    bit_cnt  <= '0;
                    dac_csel <= 1'b0;
                    state    <= DAC_SHIFT;
                end
                DAC_SHIFT: begin
                    if (!dac_sclk) begin
                        dac_sclk <= 1'b1;   // DAC samples mosi here
                    end else begin
                        dac_sclk <= 1'b0;
                        if (bit_cnt == BIT_W'(`DAC_FRAME_BITS - 1)) begin
                            dac_csel <= 1'b1;   // frame done
                            state    <= (ch == 2'd3) ? DAC_IDLE : DAC_GAP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sreg    <= sreg << 1;   // next bit while sclk low
                        end
                    end
                end
                DAC_GAP: begin
                    // one high cycle here, LOAD adds the second
                    ch    <= ch + 2'd1;
                    state <= DAC_LOAD;
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    assign dac_busy = (state != DAC_IDLE);
    assign dac_mosi = sreg[`DAC_FRAME_BITS-1];

endmodule

// ==== rtl/qla_consts.svh ====
// ------------------------------------------------
// motor controller constants
// address map, DAC frame format, safety limits
// ------------------------------------------------
`ifndef QLA_CONSTS_SVH
`define QLA_CONSTS_SVH

// address region, bits 15:12
`define ADDR_MAIN            4'h0

// register offsets, bits 3:0
`define OFF_STATUS           4'h0    // channel 0 only
`define OFF_DAC_CTRL         4'h1    // commanded current, channels 1-4
`define OFF_MOTOR_STATUS     4'hC    // amp enable + command

`define NUM_CHANNELS         4

// DAC serial frame
`define CUR_MIDSCALE         16'h8000   // zero current, offset binary
`define DAC_FRAME_BITS       24
`define DAC_CMD_WRITE_UPDATE 4'h3
`define DAC_CSEL_GAP         2          // sysclk cycles of csel high between frames

// over-current check
`define SAFETY_MARGIN        16'h0200
`define SAFETY_HOLD_CYCLES   8

`endif

// ==== rtl/qla_pkg.sv ====
// ------------------------------------------------
// shared types for the motor controller
// ------------------------------------------------
`include "qla_consts.svh"

package qla_pkg;

    typedef logic [15:0] cur_t;   // current / command code
    typedef logic [3:0]  chan_t;  // channel number

    // host register port
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_ACK_WAIT
    } bus_state_t;

    // real-time block writer
    typedef enum logic [1:0] {
        RT_COLLECT,
        RT_REPLAY,
        RT_FINISH
    } rt_state_t;

    // DAC serializer
    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_LOAD,
        DAC_SHIFT,
        DAC_GAP
    } dac_state_t;

    typedef enum logic [3:0] {
        DAC_OP_WRITE_UPDATE = `DAC_CMD_WRITE_UPDATE
    } dac_op_t;

endpackage

// ==== rtl/qla_top.sv ====
// ------------------------------------------------
// four-axis motor controller core, top level
// ------------------------------------------------
`timescale 1ns/1ps
`include "qla_consts.svh"

module qla_top (
    input  logic           sysclk,
    input  logic           reset,
    // host register port
    input  logic           host_req,
    input  logic           host_we,
    input  logic [15:0]    host_addr,
    input  logic [31:0]    host_wdata,
    output logic           host_ack,
    output logic [31:0]    host_rdata,
    // real-time block
    input  logic           rt_wen,
    input  logic [1:0]     rt_waddr,
    input  qla_pkg::cur_t  rt_wdata,
    // ADC feedback
    input  qla_pkg::cur_t  cur_fb [1:`NUM_CHANNELS],
    input  logic [3:0]     wenid,       // rotary switch
    output logic           dac_sclk,
    output logic           dac_mosi,
    output logic           dac_csel,
    output logic [3:0]     amp_enable
);
    import qla_pkg::*;

    // block writer to bus master
    logic  bw_own, bw_wen, bw_blk_wen;
    chan_t bw_chan;
    cur_t  bw_wdata;

    // register bus
    logic        board_wen, cmd_wen, blk_wen;
    chan_t       wr_chan, rd_chan;
    logic [3:0]  rd_offset;
    logic [31:0] wdata, cmd_rdata, board_rdata;

    // DAC and safety
    cur_t       cur_cmd [1:`NUM_CHANNELS];
    logic       dac_busy, data_ready;
    logic       pwr_enable_cmd;
    logic [3:0] amp_enable_cmd;
    logic [3:0] safety_disable;

    reg_bus_master reg_bus_master_inst (
        .sysclk, .reset,
        .host_req, .host_we, .host_addr, .host_wdata, .host_ack, .host_rdata,
        .bw_own, .bw_wen, .bw_blk_wen, .bw_chan, .bw_wdata,
        .board_wen, .cmd_wen, .blk_wen, .wr_chan, .rd_chan, .rd_offset, .wdata,
        .cmd_rdata, .board_rdata
    );

    rt_block_write rt_block_write_inst (
        .sysclk, .reset, .rt_wen, .rt_waddr, .rt_wdata,
        .bw_own, .bw_wen, .bw_blk_wen, .bw_chan, .bw_wdata
    );

    cur_cmd_regs cur_cmd_regs_inst (
        .sysclk, .reset, .cmd_wen, .blk_wen, .wr_chan, .rd_chan, .rd_offset, .wdata,
        .cmd_rdata, .amp_enable, .dac_busy, .data_ready, .cur_cmd
    );

    dac_serializer dac_serializer_inst (
        .sysclk, .reset, .data_ready, .cur_cmd, .dac_busy, .dac_sclk, .dac_mosi, .dac_csel
    );

    board_regs board_regs_inst (
        .sysclk, .reset, .board_wen, .wdata, .wenid, .safety_disable,
        .board_rdata, .pwr_enable_cmd, .amp_enable_cmd, .amp_enable
    );

    // one checker per axis, cleared by power or own enable
    for (genvar i = 1; i <= `NUM_CHANNELS; i++) begin : g_safety
        safety_check safety_check_inst (
            .sysclk        (sysclk),
            .reset         (reset),
            .cur_fb        (cur_fb[i]),
            .cur_cmd       (cur_cmd[i]),
            .clear_disable (pwr_enable_cmd | amp_enable_cmd[i-1]),
            .amp_disable   (safety_disable[i-1])
        );
    end

endmodule

// ==== rtl/reg_bus_master.sv ====
// ------------------------------------------------
// host req/ack port, write bus arbitration and
// address decode with read data select
// ------------------------------------------------
`timescale 1ns/1ps
`include "qla_consts.svh"

module reg_bus_master (
    input  logic               sysclk,
    input  logic               reset,
    input  logic               host_req,
    input  logic               host_we,
    input  logic [15:0]        host_addr,
    input  logic [31:0]        host_wdata,
    output logic               host_ack,
    output logic [31:0]        host_rdata,
    input  logic               bw_own,
    input  logic               bw_wen,
    input  logic               bw_blk_wen,
    input  qla_pkg::chan_t     bw_chan,
    input  qla_pkg::cur_t      bw_wdata,
    output logic               board_wen,
    output logic               cmd_wen,
    output logic               blk_wen,
    output qla_pkg::chan_t     wr_chan,
    output qla_pkg::chan_t     rd_chan,
    output logic [3:0]         rd_offset,
    output logic [31:0]        wdata,
    input  logic [31:0]        cmd_rdata,
    input  logic [31:0]        board_rdata
);
    import qla_pkg::*;

    bus_state_t  state;
    logic        host_go;     // host owns this cycle
    logic        bus_wen;
    logic [15:0] bus_addr;
    logic [31:0] rsel;

    // host gets the bus only while the block writer is off it
    assign host_go  = (state == BUS_ACCESS) && !bw_own;
    assign host_ack = (state == BUS_ACK_WAIT);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state      <= BUS_IDLE;
            host_rdata <= 32'h0;
        end else begin
            case (state)
                BUS_IDLE:     if (host_req) state <= BUS_ACCESS;
                BUS_ACCESS:   if (!bw_own) state <= BUS_ACK_WAIT;
                BUS_ACK_WAIT: if (!host_req) state <= BUS_IDLE;   // 4th phase
                default:      state <= BUS_IDLE;
            endcase
            if (host_go && !host_we)
                host_rdata <= rsel;
        end
    end

    // ------------------------------------------------
    // write bus mux
    // ------------------------------------------------
    always_comb begin
        if (bw_own) begin
            bus_wen  = bw_wen;
            bus_addr = {`ADDR_MAIN, 4'h0, bw_chan, `OFF_DAC_CTRL};
            wdata    = {16'h0, bw_wdata};
        end else begin
            bus_wen  = host_go && host_we;
            bus_addr = host_addr;
            wdata    = host_wdata;
        end
    end

    assign wr_chan   = bus_addr[7:4];
    assign board_wen = bus_wen && (bus_addr[15:12] == `ADDR_MAIN) &&
                       (wr_chan == 4'h0) && (bus_addr[3:0] == `OFF_STATUS);
    assign cmd_wen   = bus_wen && (bus_addr[15:12] == `ADDR_MAIN) && (wr_chan != 4'h0) &&
                       (wr_chan <= 4'(`NUM_CHANNELS)) && (bus_addr[3:0] == `OFF_DAC_CTRL);
    // host DAC write is a one-word block
    assign blk_wen   = bw_own ? bw_blk_wen : cmd_wen;

    // ------------------------------------------------
    // read side, host address only
    // ------------------------------------------------
    assign rd_chan   = host_addr[7:4];
    assign rd_offset = host_addr[3:0];

    always_comb begin
        rsel = 32'h0;   // unmapped reads
        if (host_addr[15:12] == `ADDR_MAIN) begin
            if (rd_chan == 4'h0)
                rsel = (rd_offset == `OFF_STATUS) ? board_rdata : 32'h0;
            else if (rd_chan <= 4'(`NUM_CHANNELS))
                rsel = cmd_rdata;
        end
    end

endmodule

// ==== rtl/rt_block_write.sv ====
// ------------------------------------------------
// real-time block write, buffers a 4-word burst
// and replays it as register bus writes
// ------------------------------------------------
`timescale 1ns/1ps

module rt_block_write (
    input  logic           sysclk,
    input  logic           reset,
    input  logic           rt_wen,
    input  logic [1:0]     rt_waddr,
    input  qla_pkg::cur_t  rt_wdata,
    output logic           bw_own,
    output logic           bw_wen,
    output logic           bw_blk_wen,
    output qla_pkg::chan_t bw_chan,
    output qla_pkg::cur_t  bw_wdata
);
    import qla_pkg::*;

    rt_state_t  state;
    cur_t       wbuf [4];   // one word per axis
    logic [1:0] cnt;        // replay index

    // burst words land as they come, no back-pressure
    always_ff @(posedge sysclk) begin
        if (rt_wen)
            wbuf[rt_waddr] <= rt_wdata;
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state <= RT_COLLECT;
            cnt   <= 2'd0;
        end else begin
            case (state)
                RT_COLLECT: if (rt_wen && rt_waddr == 2'd3) state <= RT_REPLAY;
                RT_REPLAY:  if (cnt == 2'd2) state <= RT_FINISH;
                RT_FINISH:  state <= RT_COLLECT;   // last write went out
                default:    state <= RT_COLLECT;
            endcase
            if (state != RT_COLLECT)
                cnt <= cnt + 2'd1;   // wraps to 0 after axis 4
        end
    end

    assign bw_own     = (state != RT_COLLECT);
    assign bw_wen     = bw_own;                  // one write per owned cycle
    assign bw_blk_wen = (state == RT_FINISH);    // block end on axis 4
    assign bw_chan    = {2'b00, cnt} + 4'd1;
    assign bw_wdata   = wbuf[cnt];

endmodule

// ==== rtl/safety_check.sv ====
// ------------------------------------------------
// per-axis over-current check, latched disable
// ------------------------------------------------
`timescale 1ns/1ps
`include "qla_consts.svh"

module safety_check (
    input  logic          sysclk,
    input  logic          reset,
    input  qla_pkg::cur_t cur_fb,
    input  qla_pkg::cur_t cur_cmd,
    input  logic          clear_disable,
    output logic          amp_disable
);
    localparam int HOLD   = `SAFETY_HOLD_CYCLES;
    localparam int HOLD_W = $clog2(HOLD + 1);

    logic [15:0]       fb_mag;
    logic [15:0]       cmd_mag;
    logic [17:0]       limit;      // 2*cmd + margin, no wrap
    logic              over;
    logic [HOLD_W-1:0] hold_cnt;

    // distance from midscale
    assign fb_mag  = cur_fb[15]  ? cur_fb - `CUR_MIDSCALE  : `CUR_MIDSCALE - cur_fb;
    assign cmd_mag = cur_cmd[15] ? cur_cmd - `CUR_MIDSCALE : `CUR_MIDSCALE - cur_cmd;
    assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b00, `SAFETY_MARGIN};
    assign over    = {2'b00, fb_mag} > limit;

    always_ff @(posedge sysclk) begin
        if (reset || clear_disable) begin
            hold_cnt    <= '0;
            amp_disable <= 1'b0;
        end else begin
            if (!over)
                hold_cnt <= '0;   // must be consecutive
            else if (hold_cnt != HOLD_W'(HOLD))
                hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == HOLD_W'(HOLD))
                amp_disable <= 1'b1;   // sticky until cleared
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the motor controller testbench with Verilator and run it.
# The exit status is the simulator's own: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module qla_tb -Mdir obj_dir -o qla_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/qla_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi
exit 0

// ==== tests/qla_tb.sv ====
// ------------------------------------------------
// testbench for the four-axis motor controller core
// host port, rt burst, DAC frames and safety trip
// ------------------------------------------------
`timescale 1ns/1ps
`include "qla_consts.svh"

module qla_tb;
    import qla_pkg::*;

    localparam real        CLK_PERIOD  = 8.0;
    localparam int         SET_CYCLES  = `NUM_CHANNELS * (2 * `DAC_FRAME_BITS + `DAC_CSEL_GAP + 1);
    localparam int         RUN_CYCLES  = 16 + 12 * SET_CYCLES + 2000;   // reset, sets, host traffic
    localparam real        WATCHDOG_NS = 4.0 * RUN_CYCLES * CLK_PERIOD;
    localparam logic [3:0] BOARD_ID    = 4'h5;   // rotary switch setting

    logic        sysclk;
    logic        reset;
    logic        host_req;
    logic        host_we;
    logic [15:0] host_addr;
    logic [31:0] host_wdata;
    logic        host_ack;
    logic [31:0] host_rdata;
    logic        rt_wen;
    logic [1:0]  rt_waddr;
    cur_t        rt_wdata;
    cur_t        cur_fb [1:`NUM_CHANNELS];
    logic [3:0]  wenid;
    logic        dac_sclk;
    logic        dac_mosi;
    logic        dac_csel;
    logic [3:0]  amp_enable;

    cur_t        exp_cmd [1:`NUM_CHANNELS];       // expected command per axis
    cur_t        burst_words [1:`NUM_CHANNELS];
    logic [23:0] frames [$];                      // decoded DAC frames
    logic [23:0] shift_in    = '0;
    int          bit_count   = 0;
    int          frame_index = 0;                 // axis slot within a set
    int          gap_cycles  = 0;
    logic [31:0] rng_state   = 32'd48;
    realtime     own_fall_time = 0;
    realtime     ack_rise_time = 0;

    qla_top qla_top_inst (
        .sysclk, .reset,
        .host_req, .host_we, .host_addr, .host_wdata, .host_ack, .host_rdata,
        .rt_wen, .rt_waddr, .rt_wdata,
        .cur_fb, .wenid,
        .dac_sclk, .dac_mosi, .dac_csel, .amp_enable
    );

    initial sysclk = 1'b0;
    always #(CLK_PERIOD / 2.0) sysclk = ~sysclk;

    // ------------------------------------------------
    // checking helpers
    // ------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("CHECK FAILED %s: expected 0x%08h actual 0x%08h",
                                name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_command(output cur_t value);
        rng_state = xorshift32(rng_state);
        value     = rng_state[15:0];
    endtask

    // region, zero, channel, offset
    function automatic logic [15:0] reg_addr(input int chan, input logic [3:0] offset);
        return {`ADDR_MAIN, 4'h0, 4'(chan), offset};
    endfunction

    // ------------------------------------------------
    // host port, four-phase req/ack
    // ------------------------------------------------
    task automatic host_access(input logic we, input logic [15:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata);
        @(posedge sysclk);
        #1;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = data;
        while (host_ack !== 1'b1) begin   // latency depends on bus ownership
            @(posedge sysclk);
            #1;
        end
        rdata    = host_rdata;
        host_req = 1'b0;
        while (host_ack !== 1'b0) begin
            @(posedge sysclk);
            #1;
        end
        host_we = 1'b0;
    endtask

    task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] discard;
        host_access(1'b1, addr, data, discard);
    endtask

    task automatic host_read(input logic [15:0] addr, output logic [31:0] rdata);
        host_access(1'b0, addr, 32'h0, rdata);
    endtask

    task automatic rt_burst();
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            @(posedge sysclk);
            #1;
            rt_wen   = 1'b1;
            rt_waddr = 2'(i);
            rt_wdata = burst_words[i+1];
        end
        @(posedge sysclk);
        #1;
        rt_wen = 1'b0;
    endtask

    task automatic set_feedback(input int axis, input cur_t value);
        @(posedge sysclk);
        #1;
        cur_fb[axis] = value;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #1;
    endtask

    // waits for total frames, then checks the last set against the model
    task automatic check_frame_set(input string name, input int total);
        int base;
        while (frames.size() < total) begin
            @(posedge sysclk);
            #1;
        end
        while (qla_top_inst.dac_busy) begin
            @(posedge sysclk);
            #1;
        end
        wait_cycles(16);   // an extra set would have started by now
        check_value({name, " frame count"}, 32'(total), 32'(frames.size()));
        base = total - `NUM_CHANNELS;
        for (int i = 0; i < `NUM_CHANNELS; i++)
            check_value($sformatf("%s frame %0d", name, i),
                        {8'h0, `DAC_CMD_WRITE_UPDATE, 4'(i), exp_cmd[i+1]},
                        {8'h0, frames[base + i]});
        frames.delete();
    endtask

    // ------------------------------------------------
    // DAC frame decoder
    // ------------------------------------------------
    always @(posedge sysclk) begin
        if (dac_csel === 1'b1)
            gap_cycles = gap_cycles + 1;   // csel high time
        else
            gap_cycles = 0;
    end

    always @(negedge dac_csel) begin
        shift_in  = '0;
        bit_count = 0;
        if (frame_index != 0)   // gap only inside a set
            check_value("csel gap", 32'(`DAC_CSEL_GAP), 32'(gap_cycles));
    end

    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            shift_in  = {shift_in[22:0], dac_mosi};   // MSB first
            bit_count = bit_count + 1;
        end
    end

    always @(posedge dac_csel) begin
        if (bit_count != 0) begin
            check_value("frame length", 32'(`DAC_FRAME_BITS), 32'(bit_count));
            check_value("frame axis order", 32'(frame_index), {28'h0, shift_in[19:16]});
            frames.push_back(shift_in);
            frame_index = (frame_index + 1) % `NUM_CHANNELS;
            bit_count   = 0;
        end
    end

    always @(negedge qla_top_inst.bw_own) own_fall_time = $realtime;
    always @(posedge host_ack) ack_rise_time = $realtime;

    // protocol rules checked every cycle
    ack_release: assert property (@(posedge sysclk) disable iff (reset)
        (host_ack && !host_req) |=> !host_ack)
        else fail_run("host_ack stayed high after host_req fell");

    bus_yield: assert property (@(posedge sysclk) disable iff (reset)
        (qla_top_inst.bw_own && !host_ack) |=> !host_ack)
        else fail_run("host access completed while the block writer owned the bus");

    sclk_idle: assert property (@(posedge sysclk) disable iff (reset)
        dac_csel |-> !dac_sclk)
        else fail_run("dac_sclk was high while dac_csel was inactive");

    // ------------------------------------------------
    // test sequence
    // ------------------------------------------------
    initial begin
        cur_t        value;
        logic [31:0] rdata;
        reset      = 1'b1;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = 16'h0;
        host_wdata = 32'h0;
        rt_wen     = 1'b0;
        rt_waddr   = 2'd0;
        rt_wdata   = 16'h0;
        wenid      = BOARD_ID;
        for (int i = 1; i <= `NUM_CHANNELS; i++) begin
            cur_fb[i]  = `CUR_MIDSCALE;   // zero current feedback
            exp_cmd[i] = `CUR_MIDSCALE;
        end
        wait_cycles(16);
        reset = 1'b0;

        // outputs idle, board id visible, nothing enabled
        check_value("reset host_ack", 32'h0, {31'h0, host_ack});
        check_value("reset dac_csel", 32'h1, {31'h0, dac_csel});
        check_value("reset dac_sclk", 32'h0, {31'h0, dac_sclk});
        check_value("reset amp_enable", 32'h0, {28'h0, amp_enable});
        host_read(reg_addr(0, `OFF_STATUS), rdata);
        check_value("reset status", {4'h0, ~BOARD_ID, 24'h0}, rdata);
        host_read(reg_addr(5, `OFF_DAC_CTRL), rdata);
        check_value("unmapped read", 32'h0, rdata);

        // host command writes, one DAC set each
        for (int axis = 1; axis <= `NUM_CHANNELS; axis++) begin
            next_command(value);
            exp_cmd[axis] = value;
            host_write(reg_addr(axis, `OFF_DAC_CTRL), {16'h0, value});
            check_frame_set($sformatf("host command axis %0d", axis), `NUM_CHANNELS);
            host_read(reg_addr(axis, `OFF_DAC_CTRL), rdata);
            check_value($sformatf("command readback axis %0d", axis), {16'h0, value}, rdata);
            host_read(reg_addr(axis, `OFF_MOTOR_STATUS), rdata);
            check_value($sformatf("motor status axis %0d", axis), {16'h0, value}, rdata);
        end

        // rt burst with a host read landing during the replay
        for (int i = 1; i <= `NUM_CHANNELS; i++) begin
            next_command(value);
            burst_words[i] = value;
        end
        fork
            rt_burst();
            begin
                while (qla_top_inst.bw_own !== 1'b1) begin
                    @(posedge sysclk);
                    #1;
                end
                host_read(reg_addr(3, `OFF_DAC_CTRL), rdata);
            end
        join
        for (int i = 1; i <= `NUM_CHANNELS; i++)
            exp_cmd[i] = burst_words[i];
        check_value("host read during burst", {16'h0, burst_words[3]}, rdata);
        assert (ack_rise_time > own_fall_time)
        else fail_run("host access was not held off until the burst finished");
        check_frame_set("burst", `NUM_CHANNELS);
        for (int axis = 1; axis <= `NUM_CHANNELS; axis++) begin
            host_read(reg_addr(axis, `OFF_DAC_CTRL), rdata);
            check_value($sformatf("burst readback axis %0d", axis), {16'h0, exp_cmd[axis]}, rdata);
        end

        // two writes while the DAC is still shifting
        next_command(value);
        exp_cmd[1] = value;
        host_write(reg_addr(1, `OFF_DAC_CTRL), {16'h0, value});
        while (!qla_top_inst.dac_busy) begin
            @(posedge sysclk);
            #1;
        end
        for (int axis = 2; axis <= 3; axis++) begin
            next_command(value);
            exp_cmd[axis] = value;
            assert (qla_top_inst.dac_busy)
            else fail_run("DAC went idle before a back-pressure write");
            host_write(reg_addr(axis, `OFF_DAC_CTRL), {16'h0, value});
        end
        check_frame_set("back-pressure", 2 * `NUM_CHANNELS);

        // enable all amps, small command on axis 2
        host_write(reg_addr(0, `OFF_STATUS), 32'h0000_001E);
        check_value("amps enabled", 32'hF, {28'h0, amp_enable});
        exp_cmd[2] = `CUR_MIDSCALE + 16'h0040;
        host_write(reg_addr(2, `OFF_DAC_CTRL), {16'h0, exp_cmd[2]});
        check_frame_set("safety command", `NUM_CHANNELS);

        set_feedback(2, `CUR_MIDSCALE + 16'h0200);   // under 2*0x40 + margin
        wait_cycles(4 * `SAFETY_HOLD_CYCLES);
        check_value("feedback within limit", 32'hF, {28'h0, amp_enable});
        host_read(reg_addr(0, `OFF_STATUS), rdata);
        check_value("status within limit", {4'h0, ~BOARD_ID, 12'h0, 4'hF, 8'h00}, rdata);

        set_feedback(2, `CUR_MIDSCALE - 16'h0400);   // negative, well over the limit
        wait_cycles(`SAFETY_HOLD_CYCLES + 4);
        check_value("axis 2 tripped", 32'hD, {28'h0, amp_enable});
        host_read(reg_addr(0, `OFF_STATUS), rdata);
        check_value("status tripped", {4'h0, ~BOARD_ID, 12'h0, 4'hD, 8'h02}, rdata);
        host_read(reg_addr(1, `OFF_MOTOR_STATUS), rdata);
        check_value("axis 1 still enabled", {3'b000, 1'b1, 12'h0, exp_cmd[1]}, rdata);

        // feedback back to normal, then re-enable clears the latch
        set_feedback(2, `CUR_MIDSCALE);
        host_write(reg_addr(0, `OFF_STATUS), 32'h0000_001E);
        wait_cycles(2);
        check_value("axis 2 re-enabled", 32'hF, {28'h0, amp_enable});
        host_read(reg_addr(0, `OFF_STATUS), rdata);
        check_value("status cleared", {4'h0, ~BOARD_ID, 12'h0, 4'hF, 8'h00}, rdata);

        $display("test passed");
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("watchdog timeout after %0.0f ns, the run did not finish",
                           WATCHDOG_NS));
    end

endmodule
